//--- movegen_params.svh
`default_nettype none

`ifndef MOVEGEN_PARAMS_SVH
`define MOVEGEN_PARAMS_SVH

// Board geometry
`define BOARD_FILES 8
`define BOARD_RANKS 8
// Bits per square code in the loaded board state
`define SQ_BITS 4
// Knight directions 0..7, then king directions 8..15
`define NUM_DIRS 16

`endif

`default_nettype wire

//--- movegen_pkg.sv
`include "movegen_params.svh"
`default_nettype none

package movegen_pkg;

	typedef enum logic [2:0] {
		kind_empty  = 3'd0,
		kind_pawn   = 3'd1,
		kind_knight = 3'd2,
		kind_bishop = 3'd3,
		kind_rook   = 3'd4,
		kind_queen  = 3'd5,
		kind_king   = 3'd6
	} kind_t;

	typedef struct packed {
		logic  white;
		kind_t kind;
	} piece_t;

	// An empty piece marks the absence of a token
	typedef struct packed {
		logic [2:0] src_file;
		logic [2:0] src_rank;
		piece_t     piece;
	} token_t;

	typedef struct packed {
		logic [2:0] src_file;
		logic [2:0] src_rank;
		logic [2:0] dst_file;
		logic [2:0] dst_rank;
		piece_t     piece;
	} move_t;

	typedef token_t [`NUM_DIRS-1:0] sq_tokens_t;
	typedef sq_tokens_t [`BOARD_RANKS-1:0] col_tokens_t;

	typedef enum logic [2:0] {s_idle, s_load, s_generate, s_collect, s_finish} gen_state_t;

	// Destination minus source, per direction
	localparam logic signed [2:0] dir_dfile [`NUM_DIRS] = '{
		3'sd1, 3'sd2, 3'sd2, 3'sd1, -3'sd1, -3'sd2, -3'sd2, -3'sd1,
		3'sd0, 3'sd1, 3'sd1, 3'sd1, 3'sd0, -3'sd1, -3'sd1, -3'sd1
	};
	localparam logic signed [2:0] dir_drank [`NUM_DIRS] = '{
		3'sd2, 3'sd1, -3'sd1, -3'sd2, -3'sd2, -3'sd1, 3'sd1, 3'sd2,
		3'sd1, 3'sd1, 3'sd0, -3'sd1, -3'sd1, -3'sd1, 3'sd0, 3'sd1
	};

	localparam logic [`NUM_DIRS-1:0] dir_is_knight = 16'h00ff;

endpackage

`default_nettype wire

//--- square_unit.sv
`include "movegen_params.svh"
`default_nettype none

module square_unit import movegen_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic [2:0] file,
	input  logic [2:0] rank,
	input  logic       side,
	input  piece_t     piece,
	input  sq_tokens_t tok_in,
	input  logic       capture,
	input  logic       hold,
	input  logic       report,
	output sq_tokens_t tok_out,
	output logic       pending,
	output move_t      move
);

	localparam int dir_w = $clog2(`NUM_DIRS);

	logic [`NUM_DIRS-1:0] pend_mask;
	logic [`NUM_DIRS-1:0] accept;
	logic [`NUM_DIRS-1:0] low_bit;
	logic [dir_w-1:0]     sel;

	// Source side: one token per reachable on-board destination
	always_comb begin
		logic signed [4:0] dst_f;
		logic signed [4:0] dst_r;
		logic              friendly;
		logic              kind_ok;
		logic              on_board;
		friendly = (piece.kind != kind_empty) && (piece.white == side);
		for (int d = 0; d < `NUM_DIRS; d++) begin
			dst_f = $signed({2'b00, file}) + dir_dfile[d];
			dst_r = $signed({2'b00, rank}) + dir_drank[d];
			on_board = (dst_f >= 0) && (dst_f < `BOARD_FILES) &&
				(dst_r >= 0) && (dst_r < `BOARD_RANKS);
			kind_ok = dir_is_knight[d] ? (piece.kind == kind_knight) :
				(piece.kind == kind_king);
			if (friendly && kind_ok && on_board) begin
				tok_out[d] = '{src_file: file, src_rank: rank, piece: piece};
			end else begin
				tok_out[d] = '0;
			end
		end
	end

	// Destination side: empty square or a capture of the other colour
	always_comb begin
		for (int d = 0; d < `NUM_DIRS; d++) begin
			accept[d] = (tok_in[d].piece.kind != kind_empty) &&
				((piece.kind == kind_empty) || (piece.white != tok_in[d].piece.white));
		end
	end

	// Lowest pending direction is reported first
	assign low_bit = pend_mask & (~pend_mask + 1'b1);

	always_comb begin
		sel = '0;
		for (int d = `NUM_DIRS - 1; d >= 0; d--) begin
			if (pend_mask[d])
				sel = dir_w'(d);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pend_mask <= '0;
		end else if (capture) begin
			pend_mask <= accept;
		end else if (report && !hold) begin
			pend_mask <= pend_mask & ~low_bit;
		end
	end

	assign pending = |pend_mask;

	// Board register is stable through collect, so the token still names the source
	always_comb begin
		move.src_file = tok_in[sel].src_file;
		move.src_rank = tok_in[sel].src_rank;
		move.dst_file = file;
		move.dst_rank = rank;
		move.piece    = tok_in[sel].piece;
	end

	// FSM never captures while collecting
	a_capture_report_excl: assert property (
		@(posedge clk) disable iff (!arst_n)
		!(capture && report)
	);

	a_mask_clear_after_reset: assert property (
		@(posedge clk)
		$rose(arst_n) |-> (pend_mask == '0)
	);

endmodule

`default_nettype wire

//--- column_unit.sv
`include "movegen_params.svh"
`default_nettype none

module column_unit import movegen_pkg::*; (
	input  logic                          clk,
	input  logic                          arst_n,
	input  logic [2:0]                    file,
	input  logic                          side,
	input  piece_t [`BOARD_RANKS-1:0]     squares,
	input  logic                          capture,
	input  logic                          report,
	input  col_tokens_t                   tok_in,
	output wire col_tokens_t              tok_out,
	output move_t                         move,
	output logic                          col_done
);

	wire col_tokens_t          sq_out;
	wire col_tokens_t          sq_in;
	wire [`BOARD_RANKS-1:0]    pending;
	wire move_t                sq_move [`BOARD_RANKS];
	logic [`BOARD_RANKS-1:0]   hold;
	logic [`BOARD_RANKS-1:0]   unheld;

	// King up and down stay inside the file
	for (genvar r = 0; r < `BOARD_RANKS; r++) begin : g_rank
		for (genvar d = 0; d < `NUM_DIRS; d++) begin : g_dir
			localparam int src_r = r - dir_drank[d];
			if (dir_dfile[d] == 0) begin : g_vert
				if (src_r >= 0 && src_r < `BOARD_RANKS) begin : g_link
					assign sq_in[r][d] = sq_out[src_r][d];
				end else begin : g_edge
					assign sq_in[r][d] = '0;
				end
				assign tok_out[r][d] = '0;
			end else begin : g_pass
				assign sq_in[r][d]   = tok_in[r][d];
				assign tok_out[r][d] = sq_out[r][d];
			end
		end

		square_unit u_sq (
			.clk     (clk),
			.arst_n  (arst_n),
			.file    (file),
			.rank    (3'(r)),
			.side    (side),
			.piece   (squares[r]),
			.tok_in  (sq_in[r]),
			.capture (capture),
			.hold    (hold[r]),
			.report  (report),
			.tok_out (sq_out[r]),
			.pending (pending[r]),
			.move    (sq_move[r])
		);
	end

	// Any pending lower rank holds every higher rank
	always_comb begin
		hold[0] = 1'b0;
		for (int r = 1; r < `BOARD_RANKS; r++) begin
			hold[r] = hold[r-1] | pending[r-1];
		end
	end

	assign unheld = pending & ~hold;

	always_comb begin
		move = sq_move[0];
		for (int r = `BOARD_RANKS - 1; r >= 0; r--) begin
			if (unheld[r])
				move = sq_move[r];
		end
	end

	assign col_done = ~|pending;

	// Only the one unheld pending square may give up a move
	a_one_reporter: assert property (
		@(posedge clk) disable iff (!arst_n)
		report |=> (((pending ^ $past(pending)) & ~$past(unheld)) == '0)
	);

endmodule

`default_nettype wire

//--- column_counter.sv
`include "movegen_params.svh"
`default_nettype none

module column_counter (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       clear,
	input  logic       advance,
	output logic [2:0] cur_file,
	output logic       last_file
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cur_file <= '0;
		end else if (clear) begin
			cur_file <= '0;
		end else if (advance) begin
			cur_file <= cur_file + 3'd1;
		end
	end

	assign last_file = (cur_file == 3'(`BOARD_FILES - 1));

	// FSM moves to finish instead of stepping off the board
	a_no_wrap: assert property (
		@(posedge clk) disable iff (!arst_n)
		advance |-> !last_file
	);

endmodule

`default_nettype wire

//--- movegen_fsm.sv
`include "movegen_params.svh"
`default_nettype none

module movegen_fsm import movegen_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       start,
	input  logic       col_done,
	input  logic       last_file,
	output gen_state_t state,
	output logic       gen_load,
	output logic       gen_capture,
	output logic       col_report,
	output logic       file_clear,
	output logic       file_advance,
	output logic       done
);

	gen_state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			s_idle: begin
				if (start)
					state_nxt = s_load;
			end
			s_load:     state_nxt = s_generate;
			s_generate: state_nxt = s_collect;
			s_collect: begin
				if (col_done && last_file)
					state_nxt = s_finish;
			end
			s_finish:   state_nxt = s_idle;
			default:    state_nxt = s_idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= s_idle;
		end else begin
			state <= state_nxt;
		end
	end

	assign gen_load    = (state == s_load);
	assign gen_capture = (state == s_generate);
	assign col_report  = (state == s_collect);
	// Counter restarts at file 0 for every board
	assign file_clear  = (state == s_load);
	assign file_advance = (state == s_collect) && col_done && !last_file;
	assign done        = (state == s_finish);

endmodule

`default_nettype wire

//--- movegen_top.sv
`include "movegen_params.svh"
`default_nettype none

module movegen_top import movegen_pkg::*; (
	input  logic                                          clk,
	input  logic                                          arst_n,
	input  logic                                          start,
	input  logic [`BOARD_FILES*`BOARD_RANKS*`SQ_BITS-1:0] board,
	input  logic                                          white_to_move,
	output logic                                          move_valid,
	output move_t                                         move,
	output logic                                          done
);

	localparam int col_bits = `BOARD_RANKS * `SQ_BITS;

	logic [`BOARD_FILES*col_bits-1:0] board_q;
	logic                             side_q;
	gen_state_t                       state;
	logic                             gen_load;
	logic                             gen_capture;
	logic                             col_report;
	logic                             file_clear;
	logic                             file_advance;
	logic [2:0]                       cur_file;
	logic                             last_file;
	wire [`BOARD_FILES-1:0]           col_done_v;
	wire move_t                       col_move [`BOARD_FILES];
	wire col_tokens_t                 col_out [`BOARD_FILES];
	wire col_tokens_t                 col_in [`BOARD_FILES];

	always_ff @(posedge clk) begin
		if (gen_load) begin
			board_q <= board;
			side_q  <= white_to_move;
		end
	end

	for (genvar f = 0; f < `BOARD_FILES; f++) begin : g_file
		// Cross-file links; vertical king moves are closed inside the column
		for (genvar r = 0; r < `BOARD_RANKS; r++) begin : g_rank
			for (genvar d = 0; d < `NUM_DIRS; d++) begin : g_dir
				localparam int src_f = f - dir_dfile[d];
				localparam int src_r = r - dir_drank[d];
				if (dir_dfile[d] != 0 && src_f >= 0 && src_f < `BOARD_FILES &&
						src_r >= 0 && src_r < `BOARD_RANKS) begin : g_link
					assign col_in[f][r][d] = col_out[src_f][src_r][d];
				end else begin : g_edge
					assign col_in[f][r][d] = '0;
				end
			end
		end

		column_unit u_col (
			.clk      (clk),
			.arst_n   (arst_n),
			.file     (3'(f)),
			.side     (side_q),
			.squares  (board_q[col_bits*f +: col_bits]),
			.capture  (gen_capture),
			.report   (col_report && (cur_file == 3'(f))),
			.tok_in   (col_in[f]),
			.tok_out  (col_out[f]),
			.move     (col_move[f]),
			.col_done (col_done_v[f])
		);
	end

	movegen_fsm u_fsm (
		.clk          (clk),
		.arst_n       (arst_n),
		.start        (start),
		.col_done     (col_done_v[cur_file]),
		.last_file    (last_file),
		.state        (state),
		.gen_load     (gen_load),
		.gen_capture  (gen_capture),
		.col_report   (col_report),
		.file_clear   (file_clear),
		.file_advance (file_advance),
		.done         (done)
	);

	column_counter u_cnt (
		.clk       (clk),
		.arst_n    (arst_n),
		.clear     (file_clear),
		.advance   (file_advance),
		.cur_file  (cur_file),
		.last_file (last_file)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			move_valid <= 1'b0;
		end else begin
			move_valid <= (state == s_collect) && !col_done_v[cur_file];
		end
	end

	always_ff @(posedge clk) begin
		move <= col_move[cur_file];
	end

	// A reported move carries a piece of the side to move
	a_valid_after_collect: assert property (
		@(posedge clk) disable iff (!arst_n)
		move_valid |-> ($past(state) == s_collect) && (move.piece.white == side_q) &&
			(move.piece.kind == kind_knight || move.piece.kind == kind_king)
	);

endmodule

`default_nettype wire

//--- movegen_tb.sv
`include "movegen_params.svh"
`default_nettype none

module movegen_tb import movegen_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int board_bits = `BOARD_FILES * `BOARD_RANKS * `SQ_BITS;
	localparam int n_directed = 13;
	localparam int n_random = 200;
	localparam int n_boards = n_directed + n_random;
	// Load, generate and finish plus one empty cycle per file, all moves, and gaps
	localparam int timeout_cycles = n_boards * (8 + 11 + 8 * 16) + 20;

	logic                  clk;
	logic                  arst_n;
	logic                  start;
	logic [board_bits-1:0] board;
	logic                  white_to_move;
	logic                  move_valid;
	move_t                 move;
	logic                  done;

	integer                seed;
	int                    cycle_count = 0;
	logic [board_bits-1:0] bd;
	move_t                 exp_q [$];

	movegen_top dut (
		.clk           (clk),
		.arst_n        (arst_n),
		.start         (start),
		.board         (board),
		.white_to_move (white_to_move),
		.move_valid    (move_valid),
		.move          (move),
		.done          (done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stop_run();
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
			stop_run();
		end
	end

	task automatic check_move(input move_t exp, input move_t act);
		if (act !== exp) begin
			$display("[FAIL] %0t ns move: expected %h, got %h", $time, exp, act);
			stop_run();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("[FAIL] %0t ns %s: expected %0d, got %0d", $time, name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_done(input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] %0t ns done: expected %b, got %b", $time, exp, act);
			stop_run();
		end
	endtask

	// Reference model: destinations by file, then rank, then direction
	task automatic build_expected(input logic [board_bits-1:0] b, input logic side);
		piece_t sp;
		piece_t tp;
		move_t  m;
		int     sf;
		int     sr;
		int     df;
		int     dr;
		exp_q.delete();
		for (int f = 0; f < `BOARD_FILES; f++) begin
			for (int r = 0; r < `BOARD_RANKS; r++) begin
				tp = b[`SQ_BITS * (8 * f + r) +: `SQ_BITS];
				for (int d = 0; d < `NUM_DIRS; d++) begin
					df = dir_dfile[d];
					dr = dir_drank[d];
					sf = f - df;
					sr = r - dr;
					if (sf < 0 || sf > 7 || sr < 0 || sr > 7)
						continue;
					sp = b[`SQ_BITS * (8 * sf + sr) +: `SQ_BITS];
					if (sp.kind == kind_empty || sp.white != side)
						continue;
					if (sp.kind != (d < 8 ? kind_knight : kind_king))
						continue;
					if (tp.kind != kind_empty && tp.white == sp.white)
						continue;
					m.src_file = sf[2:0];
					m.src_rank = sr[2:0];
					m.dst_file = f[2:0];
					m.dst_rank = r[2:0];
					m.piece    = sp;
					exp_q.push_back(m);
				end
			end
		end
	endtask

	task automatic clear_board();
		bd = '0;
	endtask

	task automatic put(input int f, input int r, input logic white, input kind_t k);
		piece_t p;
		p.white = white;
		p.kind  = k;
		bd[`SQ_BITS * (8 * f + r) +: `SQ_BITS] = p;
	endtask

	task automatic random_board(output logic [board_bits-1:0] b);
		logic [31:0] rnd;
		piece_t      p;
		for (int s = 0; s < 64; s++) begin
			rnd = $random(seed);
			if (rnd[0]) begin
				p = '0;
			end else begin
				p.kind  = kind_t'(rnd[3:1] % 3'd6 + 3'd1);
				p.white = rnd[4];
			end
			b[`SQ_BITS * s +: `SQ_BITS] = p;
		end
	endtask

	// One board from start to done; poke sends a stray start during collect
	task automatic run_board(input logic [board_bits-1:0] b, input logic side, input bit poke);
		int          n_exp;
		int          got;
		int          cycles;
		logic        seen_done;
		logic [31:0] rnd;
		build_expected(b, side);
		n_exp = exp_q.size();
		got = 0;
		cycles = 0;
		seen_done = 1'b0;
		@(negedge clk);
		board = b;
		white_to_move = side;
		start = 1'b1;
		while (!seen_done) begin
			@(negedge clk);
			cycles++;
			if (cycles == 1)
				start = 1'b0;
			if (poke && cycles == 3) begin
				rnd = $random(seed);
				board = {8{rnd}};
				start = 1'b1;
			end
			if (poke && cycles == 4)
				start = 1'b0;
			if (move_valid) begin
				if (exp_q.size() == 0) begin
					$display("Extra move %h reported at %0t ns", move, $time);
					stop_run();
				end else begin
					check_move(exp_q.pop_front(), move);
					got++;
				end
			end
			check_done(cycles == n_exp + 11, done);
			seen_done = done;
		end
		check_count("move count", n_exp, got);
		@(negedge clk);
		check_done(1'b0, done);
	endtask

	initial begin
		logic [board_bits-1:0] rb;
		logic [31:0]           rnd;
		seed = 32'h1b07;
		arst_n = 1'b0;
		start = 1'b0;
		board = '0;
		white_to_move = 1'b0;
		repeat (2) @(negedge clk);
		arst_n = 1'b1;

		// No movers at all
		clear_board();
		run_board(bd, 1'b1, 1'b0);
		run_board(bd, 1'b0, 1'b0);
		clear_board();
		put(3, 3, 1'b1, kind_knight);
		put(4, 0, 1'b1, kind_king);
		put(2, 6, 1'b0, kind_pawn);
		put(5, 6, 1'b0, kind_rook);
		run_board(bd, 1'b0, 1'b0);

		// Lone pieces, centre and edges
		clear_board();
		put(3, 3, 1'b1, kind_knight);
		run_board(bd, 1'b1, 1'b0);
		clear_board();
		put(0, 0, 1'b1, kind_knight);
		run_board(bd, 1'b1, 1'b0);
		clear_board();
		put(4, 4, 1'b1, kind_king);
		run_board(bd, 1'b1, 1'b0);
		clear_board();
		put(7, 0, 1'b1, kind_king);
		run_board(bd, 1'b1, 1'b0);
		clear_board();
		put(0, 5, 1'b0, kind_king);
		run_board(bd, 1'b0, 1'b0);

		// Blockers and captures, both colours to move
		clear_board();
		put(3, 3, 1'b1, kind_knight);
		put(4, 5, 1'b1, kind_pawn);
		put(5, 4, 1'b0, kind_pawn);
		put(6, 6, 1'b1, kind_king);
		put(6, 7, 1'b1, kind_rook);
		put(7, 7, 1'b0, kind_queen);
		run_board(bd, 1'b1, 1'b0);
		run_board(bd, 1'b0, 1'b0);
		clear_board();
		put(3, 3, 1'b0, kind_knight);
		put(4, 5, 1'b0, kind_pawn);
		put(5, 4, 1'b1, kind_pawn);
		put(6, 6, 1'b0, kind_king);
		put(6, 7, 1'b0, kind_rook);
		put(7, 7, 1'b1, kind_queen);
		run_board(bd, 1'b0, 1'b0);

		// Shared destinations and crowded files
		clear_board();
		put(1, 1, 1'b1, kind_knight);
		put(5, 3, 1'b1, kind_knight);
		put(1, 3, 1'b1, kind_knight);
		put(3, 3, 1'b1, kind_king);
		put(3, 2, 1'b0, kind_bishop);
		run_board(bd, 1'b1, 1'b0);
		clear_board();
		for (int r = 0; r < `BOARD_RANKS; r++)
			put(2, r, 1'b1, kind_knight);
		run_board(bd, 1'b1, 1'b0);

		for (int i = 0; i < n_random; i++) begin
			random_board(rb);
			rnd = $random(seed);
			run_board(rb, rnd[0], i[0]);
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+.
movegen_pkg.sv
square_unit.sv
column_unit.sv
column_counter.sv
movegen_fsm.sv
movegen_top.sv
movegen_tb.sv
